/* adc_data_pkg.sv */
`default_nettype none

package adc_data_pkg;

  // ******************************
  // data path widths
  // ******************************

  // width of a corrected sample on the channel output
  // the format block widens every raw code to this width
  // the dc filter works on words of this width from input to output
  localparam int DATA_WIDTH_DEF = 16;

  // ******************************
  // fixed-point constants
  // ******************************

  // fraction bits that the dc estimate carries below the sample lsb
  // the estimate is DATA_WIDTH + ACC_FRAC_BITS wide, with the integer part on top
  // 16 bits keep the small per-sample updates from being lost when the
  // coefficient is low, which means a slow corner frequency
  localparam int ACC_FRAC_BITS = 16;

endpackage : adc_data_pkg

`default_nettype wire

/* adc_cfg_pkg.sv */
`default_nettype none

package adc_cfg_pkg;

  // ******************************
  // control input widths
  // ******************************

  // filter coefficient, unsigned with COEFF_FRAC_BITS fraction bits
  // 32768 is 1.0 and a typical setting is far below that
  localparam int COEFF_WIDTH     = 16;
  localparam int COEFF_FRAC_BITS = 15;

  // default converter resolution in bits
  localparam int ADC_RES_DEF = 12;

  // ******************************
  // format select encodings
  // ******************************

  // converter already delivers two's complement codes
  localparam logic FMT_TWOS       = 1'b0;
  // converter delivers offset binary, mid-scale is 100..0
  localparam logic FMT_OFFSET_BIN = 1'b1;

endpackage : adc_cfg_pkg

`default_nettype wire

/* adc_data_format.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_data_format #(
  // width of the widened sample
  parameter int DATA_WIDTH = adc_data_pkg::DATA_WIDTH_DEF,
  // converter resolution, 8 up to DATA_WIDTH
  parameter int ADC_RES    = adc_cfg_pkg::ADC_RES_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // raw converter samples
  input  logic                  in_valid,
  input  logic [ADC_RES-1:0]    in_data,

  // static control
  input  logic                  fmt_sel,
  input  logic                  fmt_enb,

  // formatted samples, one cycle later
  output logic                  fmt_valid,
  output logic [DATA_WIDTH-1:0] fmt_data
);

  import adc_cfg_pkg::*;

  // code after the optional msb flip
  logic [ADC_RES-1:0]    code_conv;
  // code widened to the data path
  logic [DATA_WIDTH-1:0] data_ext;

  // ******************************
  // code conversion
  // ******************************

  always_comb begin
    code_conv = in_data;
    // offset binary becomes two's complement by inverting the top bit
    if (fmt_enb) begin
      case (fmt_sel)
        FMT_OFFSET_BIN: code_conv[ADC_RES-1] = ~in_data[ADC_RES-1];
        FMT_TWOS:       code_conv = in_data;
      endcase
    end
  end

  always_comb begin
    if (fmt_enb) begin
      // sign extension from ADC_RES to DATA_WIDTH
      data_ext = DATA_WIDTH'(signed'(code_conv));
    end else begin
      // format bypass, raw code zero-extended
      data_ext = DATA_WIDTH'(in_data);
    end
  end

  // ******************************
  // output register
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fmt_valid <= 1'b0;
      fmt_data  <= '0;
    end else begin
      fmt_valid <= in_valid;
      // data only moves with a valid sample
      if (in_valid) begin
        fmt_data <= data_ext;
      end
    end
  end

endmodule : adc_data_format

`default_nettype wire

/* dc_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module dc_filter #(
  // sample width on input and output
  parameter int DATA_WIDTH = adc_data_pkg::DATA_WIDTH_DEF
) (
  input  logic                                clk,
  input  logic                                rst_n,

  // formatted samples
  input  logic                                fmt_valid,
  input  logic [DATA_WIDTH-1:0]               fmt_data,

  // static control
  input  logic                                dcfilt_enb,
  input  logic [adc_cfg_pkg::COEFF_WIDTH-1:0] dcfilt_coeff,
  input  logic [DATA_WIDTH-1:0]               dcfilt_offset,

  // corrected samples, three cycles later
  output logic                                out_valid,
  output logic [DATA_WIDTH-1:0]               out_data
);

  import adc_data_pkg::*;
  import adc_cfg_pkg::*;

  // dc estimate width, integer part on top of the fraction bits
  localparam int ACC_W  = DATA_WIDTH + ACC_FRAC_BITS;
  // x minus estimate needs one extra bit
  localparam int DIFF_W = ACC_W + 1;
  // signed difference times coefficient with a zero sign bit added
  localparam int PROD_W = DIFF_W + COEFF_WIDTH + 1;
  // correction before saturation
  localparam int CORR_W = DATA_WIDTH + 1;

  // saturation limits
  localparam logic signed [DATA_WIDTH-1:0] SAT_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
  localparam logic signed [DATA_WIDTH-1:0] SAT_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  // stage 1 registers
  logic                          valid_d1;
  logic signed [DATA_WIDTH-1:0]  x_d1;

  // stage 2 registers
  logic                          valid_d2;
  logic                          enb_d2;
  logic signed [DATA_WIDTH-1:0]  x_d2;
  logic signed [ACC_W-1:0]       acc;

  // stage 2 arithmetic
  logic signed [ACC_W-1:0]       x_scaled;
  logic signed [DIFF_W-1:0]      diff;
  logic signed [COEFF_WIDTH:0]   coeff_s;
  logic signed [PROD_W-1:0]      prod;
  logic signed [PROD_W-1:0]      step;
  logic signed [PROD_W-1:0]      acc_sum;
  logic signed [ACC_W-1:0]       acc_next;

  // stage 3 arithmetic
  logic signed [DATA_WIDTH-1:0]  dc_int;
  logic signed [CORR_W-1:0]      corr;
  logic signed [DATA_WIDTH-1:0]  corr_sat;

  // ******************************
  // stage 1, offset add
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d1 <= 1'b0;
      x_d1     <= '0;
    end else begin
      valid_d1 <= fmt_valid;
      // wraps modulo 2**DATA_WIDTH
      if (fmt_valid) begin
        x_d1 <= fmt_data + dcfilt_offset;
      end
    end
  end

  // ******************************
  // stage 2, dc estimate update
  // ******************************

  // acc += ((x * 2**ACC_FRAC_BITS - acc) * coeff) >>> COEFF_FRAC_BITS
  always_comb begin
    x_scaled = {x_d1, {ACC_FRAC_BITS{1'b0}}};
    diff     = DIFF_W'(x_scaled) - DIFF_W'(acc);
    // coefficient is unsigned, force a positive signed operand
    coeff_s  = {1'b0, dcfilt_coeff};
    prod     = PROD_W'(diff) * PROD_W'(coeff_s);
    step     = prod >>> COEFF_FRAC_BITS;
    acc_sum  = step + PROD_W'(acc);
    // wraps back into the estimate width
    acc_next = acc_sum[ACC_W-1:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_d2 <= 1'b0;
      enb_d2   <= 1'b0;
      x_d2     <= '0;
      acc      <= '0;
    end else begin
      valid_d2 <= valid_d1;
      if (valid_d1) begin
        x_d2   <= x_d1;
        // enable travels with the sample so stage 3 matches stage 2
        enb_d2 <= dcfilt_enb;
        // estimate holds while the filter is off
        if (dcfilt_enb) begin
          acc <= acc_next;
        end
      end
    end
  end

  // ******************************
  // stage 3, dc removal
  // ******************************

  always_comb begin
    // integer part of the updated estimate
    dc_int = DATA_WIDTH'(acc >>> ACC_FRAC_BITS);
    corr   = CORR_W'(x_d2) - CORR_W'(dc_int);
    // top two bits differ when the result left the signed range
    if (corr[CORR_W-1] != corr[CORR_W-2]) begin
      corr_sat = corr[CORR_W-1] ? SAT_MIN : SAT_MAX;
    end else begin
      corr_sat = corr[DATA_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      out_valid <= valid_d2;
      if (valid_d2) begin
        // filter off passes the offset sample through
        out_data <= enb_d2 ? corr_sat : x_d2;
      end
    end
  end

endmodule : dc_filter

`default_nettype wire

/* adc_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_channel #(
  // corrected sample width
  parameter int DATA_WIDTH = adc_data_pkg::DATA_WIDTH_DEF,
  // converter resolution
  parameter int ADC_RES    = adc_cfg_pkg::ADC_RES_DEF
) (
  input  logic                                clk,
  input  logic                                rst_n,

  // raw converter samples, no back-pressure
  input  logic                                in_valid,
  input  logic [ADC_RES-1:0]                  in_data,

  // format control
  input  logic                                fmt_sel,
  input  logic                                fmt_enb,

  // dc filter control
  input  logic                                dcfilt_enb,
  input  logic [adc_cfg_pkg::COEFF_WIDTH-1:0] dcfilt_coeff,
  input  logic [DATA_WIDTH-1:0]               dcfilt_offset,

  // corrected samples, four cycles after in_valid
  output logic                                out_valid,
  output logic [DATA_WIDTH-1:0]               out_data
);

  // formatted samples between the two blocks
  logic                  fmt_valid;
  logic [DATA_WIDTH-1:0] fmt_data;

  // ******************************
  // format, 1 cycle
  // ******************************

  adc_data_format #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADC_RES    (ADC_RES)
  ) u_format (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .fmt_sel   (fmt_sel),
    .fmt_enb   (fmt_enb),
    .fmt_valid (fmt_valid),
    .fmt_data  (fmt_data)
  );

  // ******************************
  // dc filter, 3 cycles
  // ******************************

  dc_filter #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_dcfilt (
    .clk           (clk),
    .rst_n         (rst_n),
    .fmt_valid     (fmt_valid),
    .fmt_data      (fmt_data),
    .dcfilt_enb    (dcfilt_enb),
    .dcfilt_coeff  (dcfilt_coeff),
    .dcfilt_offset (dcfilt_offset),
    .out_valid     (out_valid),
    .out_data      (out_data)
  );

endmodule : adc_channel

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS    = 10.0,
  parameter int  RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n,
  // extra reset request from the testbench, active high
  input  logic rst_req
);

  // power-on part of the reset
  logic init_n;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // released on a falling edge, clear of the rising edge
  initial begin
    init_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    init_n <= 1'b1;
  end

  assign rst_n = init_n & ~rst_req;

endmodule : tb_clk_gen

`default_nettype wire

/* adc_channel_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_channel_sva #(
  parameter int DATA_WIDTH = adc_data_pkg::DATA_WIDTH_DEF
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  in_valid,
  input logic                  out_valid,
  input logic [DATA_WIDTH-1:0] out_data
);

  // ******************************
  // valid timing, four cycles
  // ******************************

  a_valid_follows : assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> ##4 out_valid)
    else $error("out_valid missing four cycles after in_valid");

  a_no_extra_valid : assert property (@(posedge clk) disable iff (!rst_n)
    !in_valid |-> ##4 !out_valid)
    else $error("out_valid high without a matching in_valid");

  // ******************************
  // reset and data
  // ******************************

  a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high during reset");

  a_data_known : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_data))
    else $error("out_data unknown while out_valid is high");

endmodule : adc_channel_sva

bind adc_channel adc_channel_sva #(.DATA_WIDTH(DATA_WIDTH)) u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_data  (out_data)
);

`default_nettype wire

/* tb_adc_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_channel;

  import adc_data_pkg::*;
  import adc_cfg_pkg::*;

  localparam int DATA_WIDTH = DATA_WIDTH_DEF;
  localparam int ADC_RES    = ADC_RES_DEF;
  localparam int SAT_MAX    = (1 << (DATA_WIDTH - 1)) - 1;
  localparam int SAT_MIN    = -(1 << (DATA_WIDTH - 1));
  // about 1300 samples at 70% density plus drains come to near 2000 cycles
  localparam int TIMEOUT_CYCLES = 3000;

  logic                         clk;
  logic                         rst_n;
  logic                         rst_req;
  logic                         in_valid;
  logic [ADC_RES-1:0]           in_data;
  logic                         fmt_sel;
  logic                         fmt_enb;
  logic                         dcfilt_enb;
  logic [COEFF_WIDTH-1:0]       dcfilt_coeff;
  logic [DATA_WIDTH-1:0]        dcfilt_offset;
  logic                         out_valid;
  logic [DATA_WIDTH-1:0]        out_data;

  // scoreboard holds the expected sample and the cycle it is due
  logic [DATA_WIDTH-1:0]        exp_q[$];
  int                           due_q[$];
  int                           cycles = 0;
  // model copy of the dc estimate in the filter's fixed point
  int                           model_acc;
  logic signed [DATA_WIDTH-1:0] last_out;
  int                           sat_hi;
  int                           sat_lo;

  tb_clk_gen u_clk (
    .clk     (clk),
    .rst_n   (rst_n),
    .rst_req (rst_req)
  );

  adc_channel #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADC_RES    (ADC_RES)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_data       (in_data),
    .fmt_sel       (fmt_sel),
    .fmt_enb       (fmt_enb),
    .dcfilt_enb    (dcfilt_enb),
    .dcfilt_coeff  (dcfilt_coeff),
    .dcfilt_offset (dcfilt_offset),
    .out_valid     (out_valid),
    .out_data      (out_data)
  );

  // ******************************
  // reporting
  // ******************************

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      fail_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, want));
    end
  endtask

  // ******************************
  // reference model
  // ******************************

  function automatic logic [DATA_WIDTH-1:0] model_output(input logic [ADC_RES-1:0] code);
    int     val;
    int     x;
    int     dc;
    int     corr;
    longint diff;
    longint upd;
    val = int'(code);
    if (fmt_enb) begin
      // offset binary is two's complement with the msb flipped
      if (fmt_sel == FMT_OFFSET_BIN) begin
        val = val ^ (1 << (ADC_RES - 1));
      end
      if (val >= (1 << (ADC_RES - 1))) begin
        val = val - (1 << ADC_RES);
      end
    end
    // offset add wraps and the word is then read as signed
    x = (val + int'(dcfilt_offset)) & ((1 << DATA_WIDTH) - 1);
    if (x >= (1 << (DATA_WIDTH - 1))) begin
      x = x - (1 << DATA_WIDTH);
    end
    if (!dcfilt_enb) begin
      return DATA_WIDTH'(x);
    end
    // acc moves by coeff/32768 of the distance to x
    diff      = longint'(x) * (longint'(1) << ACC_FRAC_BITS) - longint'(model_acc);
    upd       = (diff * longint'(dcfilt_coeff)) >>> COEFF_FRAC_BITS;
    model_acc = int'(longint'(model_acc) + upd);
    dc        = model_acc >>> ACC_FRAC_BITS;
    corr      = x - dc;
    if (corr > SAT_MAX) begin
      corr = SAT_MAX;
    end else if (corr < SAT_MIN) begin
      corr = SAT_MIN;
    end
    return DATA_WIDTH'(corr);
  endfunction

  // ******************************
  // stimulus helpers
  // ******************************

  // outputs only stop once the pipeline is empty
  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic configure_channel(input logic f_enb, input logic f_sel, input logic d_enb,
                                   input logic [COEFF_WIDTH-1:0] coeff,
                                   input logic [DATA_WIDTH-1:0] offset);
    drain();
    @(negedge clk);
    fmt_enb       <= f_enb;
    fmt_sel       <= f_sel;
    dcfilt_enb    <= d_enb;
    dcfilt_coeff  <= coeff;
    dcfilt_offset <= offset;
  endtask

  task automatic send_stream(input int count, input bit use_const,
                             input logic [ADC_RES-1:0] const_code);
    int                    sent;
    logic [ADC_RES-1:0]    code;
    logic [DATA_WIDTH-1:0] want;
    sent = 0;
    while (sent < count) begin
      @(negedge clk);
      if ($urandom_range(99) < 70) begin
        code = use_const ? const_code : ADC_RES'($urandom);
        want = model_output(code);
        in_valid <= 1'b1;
        in_data  <= code;
        exp_q.push_back(want);
        // four rising edges until it shows on the output
        due_q.push_back(cycles + 4);
        if (want == DATA_WIDTH'(SAT_MAX)) begin
          sat_hi++;
        end
        if (want == DATA_WIDTH'(SAT_MIN)) begin
          sat_lo++;
        end
        sent++;
      end else begin
        in_valid <= 1'b0;
        in_data  <= ADC_RES'($urandom);
      end
    end
    @(negedge clk);
    in_valid <= 1'b0;
  endtask

  // reset while samples are still in the pipeline
  task automatic reset_midstream();
    @(negedge clk);
    rst_req <= 1'b1;
    // without reset the last sample would be on out_valid by now
    repeat (2) @(negedge clk);
    check_value("out_valid", out_valid, 1'b0);
    exp_q.delete();
    due_q.delete();
    model_acc = 0;
    @(negedge clk);
    rst_req <= 1'b0;
  endtask

  // ******************************
  // compare and timeout
  // ******************************

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        fail_run("out_valid was high while no sample was in flight");
      end else begin
        check_value("out_data", out_data, exp_q.pop_front());
        check_value("out_valid latency", cycles, due_q.pop_front());
        last_out = out_data;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run("timeout, the test sequence did not finish in time");
    end
  end

  // ******************************
  // test sequence
  // ******************************

  initial begin
    logic [DATA_WIDTH-1:0] blk_offset[4];
    void'($urandom(39098));
    rst_req       = 1'b0;
    in_valid      = 1'b0;
    in_data       = '0;
    fmt_sel       = FMT_TWOS;
    fmt_enb       = 1'b1;
    dcfilt_enb    = 1'b0;
    dcfilt_coeff  = '0;
    dcfilt_offset = '0;
    model_acc     = 0;
    sat_hi        = 0;
    sat_lo        = 0;
    while (rst_n !== 1'b1) @(negedge clk);

    // format modes with the filter off
    configure_channel(1'b1, FMT_TWOS, 1'b0, 16'd0, 16'd0);
    send_stream(100, 1'b0, '0);
    configure_channel(1'b1, FMT_OFFSET_BIN, 1'b0, 16'd0, 16'd0);
    send_stream(100, 1'b0, '0);
    configure_channel(1'b0, FMT_TWOS, 1'b0, 16'd0, 16'd0);
    send_stream(100, 1'b0, '0);

    // offset add where some offsets wrap past the 16 bit range
    blk_offset = '{16'h7f80, 16'h8040, 16'hfff0, 16'h0000};
    blk_offset[3] = DATA_WIDTH'($urandom);
    for (int i = 0; i < 4; i++) begin
      configure_channel(1'b1, FMT_TWOS, 1'b0, 16'd0, blk_offset[i]);
      send_stream(12, 1'b0, '0);
    end

    // dc removal on a constant input
    configure_channel(1'b1, FMT_TWOS, 1'b1, 16'd2048, 16'd0);
    send_stream(300, 1'b1, 12'd1000);
    drain();
    if (last_out > 1 || last_out < -1) begin
      fail_run("dc level was still present after 300 samples");
    end

    // random samples where large offsets swing the output into saturation
    sat_hi = 0;
    sat_lo = 0;
    blk_offset = '{16'h0000, 16'h8800, 16'h7800, 16'h8800};
    blk_offset[0] = DATA_WIDTH'($urandom);
    for (int i = 0; i < 4; i++) begin
      configure_channel(1'b1, FMT_TWOS, 1'b1, COEFF_WIDTH'($urandom_range(4095, 1024)),
                        blk_offset[i]);
      send_stream(100, 1'b0, '0);
    end
    drain();
    if (sat_hi == 0 || sat_lo == 0) begin
      fail_run("saturation was not reached at both ends");
    end

    // estimate holds while the filter is off
    configure_channel(1'b1, FMT_TWOS, 1'b1, 16'd1024, 16'd0);
    send_stream(40, 1'b1, 12'd500);
    configure_channel(1'b1, FMT_TWOS, 1'b0, 16'd1024, 16'd0);
    send_stream(100, 1'b1, 12'd500);
    configure_channel(1'b1, FMT_TWOS, 1'b1, 16'd1024, 16'd0);
    send_stream(40, 1'b1, 12'd500);

    // reset with samples in flight so the estimate starts again at zero
    configure_channel(1'b1, FMT_TWOS, 1'b1, 16'd4096, 16'd0);
    send_stream(20, 1'b0, '0);
    reset_midstream();
    send_stream(50, 1'b0, '0);

    repeat (10) @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      fail_run("expected samples never came out of the channel");
    end
  end

endmodule : tb_adc_channel

`default_nettype wire

/* flist.f */
adc_data_pkg.sv
adc_cfg_pkg.sv
adc_data_format.sv
dc_filter.sv
adc_channel.sv
tb_clk_gen.sv
adc_channel_sva.sv
tb_adc_channel.sv

/* Bender.yml */
package:
  name: adc_channel

sources:
  # packages first, then the blocks below the top level
  - adc_data_pkg.sv
  - adc_cfg_pkg.sv
  - adc_data_format.sv
  - dc_filter.sv
  - adc_channel.sv

  # testbench, only in simulation
  - target: test
    files:
      - tb_clk_gen.sv
      - adc_channel_sva.sv
      - tb_adc_channel.sv
